// File: hdl/rf_pkg.sv
`default_nettype none

package rf_pkg;

  // ============================================================
  // register file geometry
  // ============================================================
  localparam int NTHREADS = 4;                  // barrel-threaded hw threads
  localparam int NREGS    = 32;                 // gprs per thread
  localparam int TID_W    = $clog2(NTHREADS);   // thread id width
  localparam int REG_W    = $clog2(NREGS);      // register number width
  localparam int ADDR_W   = TID_W + REG_W;      // flat address, tid on top

  // word and lane layout
  localparam int DATA_W = 32;
  localparam int NLANES = 4;                    // byte lanes per word
  localparam int LANE_W = DATA_W / NLANES;      // 8 bits per lane

  typedef logic [DATA_W-1:0] value_t;

  // ============================================================
  // client payloads
  // ============================================================
  // write slot payload, field order matches the top level concat
  typedef struct packed {
    logic [TID_W-1:0]  tid;    // target thread
    logic [REG_W-1:0]  rnum;   // target register
    logic [NLANES-1:0] be;     // byte lanes to update
    value_t            value;  // write data
  } wr_req_t;

  // read slot payload
  typedef struct packed {
    logic [TID_W-1:0] tid;
    logic [REG_W-1:0] rnum;
  } rd_req_t;

endpackage

`default_nettype wire

// File: hdl/req_slot.sv
`timescale 1ns/1ps
`default_nettype none

module req_slot #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     req,       // four-phase request from client
  output logic     ack,       // registered acknowledge
  input  payload_t req_data,  // client fields, stable while req high
  output logic     pending,   // slot holds an unserviced request
  output payload_t payload,   // latched copy of req_data
  input  logic     done       // service finished this cycle
);

  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,  // waiting for req
    ST_PEND  = 2'd1,  // latched, waiting for service
    ST_ACKED = 2'd2   // ack up, waiting for req to drop
  } state_e;

  state_e state;

  // ============================================================
  // handshake fsm
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE:  if (req) state <= ST_PEND;    // accept on first req seen
        ST_PEND:  if (done) state <= ST_ACKED;  // ack one edge after done
        ST_ACKED: if (!req) state <= ST_IDLE;   // ack falls after req low
        default:  state <= ST_IDLE;
      endcase
    end
  end

  // payload capture, only when a new request is accepted
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && req) begin
      payload <= req_data;
    end
  end

  assign pending = (state == ST_PEND);
  assign ack     = (state == ST_ACKED);  // straight decode of the state flop

  // ack only ever rises on an edge where the client was requesting
  a_ack_needs_req : assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ack) |-> $past(req));

  // the serving unit must not complete a request this slot does not hold
  a_done_when_pending : assert property (@(posedge clk) disable iff (!rst_n)
    done |-> pending);

endmodule

`default_nettype wire

// File: hdl/wr_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module wr_arbiter (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       pend_a,  // alu slot pending
  input  logic                       pend_b,  // load slot pending
  input  rf_pkg::wr_req_t            req_a,
  input  rf_pkg::wr_req_t            req_b,
  output logic                       done_a,  // high in the cycle of its write
  output logic                       done_b,
  output logic [rf_pkg::NLANES-1:0]  wr,      // byte lane enables to memory
  output logic [rf_pkg::ADDR_W-1:0]  wa,
  output rf_pkg::value_t             wdata
);

  logic            prio_b;  // set when slot b wins a tie
  logic            grant_a;
  logic            grant_b;
  rf_pkg::wr_req_t sel;     // winner's payload

  // ============================================================
  // round-robin pick
  // ============================================================
  // each side wins when alone or when it holds priority
  assign grant_a = pend_a && (!pend_b || !prio_b);
  assign grant_b = pend_b && (!pend_a ||  prio_b);

  // after a grant the loser of the tie gets first pick next time
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prio_b <= 1'b0;         // alu side favoured out of reset
    end else if (grant_a) begin
      prio_b <= 1'b1;
    end else if (grant_b) begin
      prio_b <= 1'b0;
    end
  end

  // ============================================================
  // write port mux
  // ============================================================
  always_comb begin
    sel = req_a;
    if (grant_b) begin
      sel = req_b;
    end
  end

  always_comb begin
    if (grant_a || grant_b) begin
      wr = sel.be;            // lanes straight from the client mask
    end else begin
      wr = '0;                // idle port writes nothing
    end
  end

  assign wa     = {sel.tid, sel.rnum};  // thread id in the upper bits
  assign wdata  = sel.value;
  assign done_a = grant_a;
  assign done_b = grant_b;

  // a winning slot leaves pending before the next cycle, one write per request
  a_once_a : assert property (@(posedge clk) disable iff (!rst_n)
    done_a |=> !done_a);
  a_once_b : assert property (@(posedge clk) disable iff (!rst_n)
    done_b |=> !done_b);

endmodule

`default_nettype wire

// File: hdl/operand_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module operand_fetch (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      pending,  // read slot holds a request
  input  rf_pkg::rd_req_t           rq,       // latched tid and register
  output logic                      done,     // data captured next edge
  output logic                      ce,       // load regfile read address
  output logic [rf_pkg::ADDR_W-1:0] ra,
  input  rf_pkg::value_t            o,        // regfile read data
  output rf_pkg::value_t            rd_data   // held until next read
);

  logic issued;  // address registered in regfile, o is valid now

  // ============================================================
  // two step sequence: issue, then capture
  // ============================================================
  // step 1, first pending cycle sends the address
  assign ce = pending && !issued;
  assign ra = {rq.tid, rq.rnum};

  // step 2, o carries the word, slot acks on the same edge we capture
  assign done = issued;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issued <= 1'b0;
    end else begin
      issued <= ce;           // one cycle pulse after each issue
    end
  end

  // capture register, visible together with ack
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_data <= '0;
    end else if (issued) begin
      rd_data <= o;
    end
  end

endmodule

`default_nettype wire

// File: hdl/gpr_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module gpr_regfile #(
  parameter bit ZERO_BYPASS = 1'b0  // r0 of every thread reads as zero
) (
  input  logic                      clk,
  input  logic                      ce,  // read address load
  input  logic [rf_pkg::NLANES-1:0] wr,  // per lane write enable
  input  logic [rf_pkg::ADDR_W-1:0] wa,
  input  rf_pkg::value_t            i,
  input  logic [rf_pkg::ADDR_W-1:0] ra,
  output rf_pkg::value_t            o
);

  localparam int DEPTH = rf_pkg::NTHREADS * rf_pkg::NREGS;

  rf_pkg::value_t              mem [DEPTH];  // one word per thread/register
  logic [rf_pkg::ADDR_W-1:0]   rar;          // registered read address

  // ============================================================
  // storage
  // ============================================================
  // all threads start with cleared registers
  initial begin
    for (int k = 0; k < DEPTH; k++) begin
      mem[k] = '0;
    end
  end

  // byte lane writes, mask alone decides
  always_ff @(posedge clk) begin
    for (int l = 0; l < rf_pkg::NLANES; l++) begin
      if (wr[l]) begin
        mem[wa][l*rf_pkg::LANE_W +: rf_pkg::LANE_W] <= i[l*rf_pkg::LANE_W +: rf_pkg::LANE_W];
      end
    end
  end

  // ============================================================
  // read side
  // ============================================================
  always_ff @(posedge clk) begin
    if (ce) begin
      rar <= ra;              // one cycle read latency
    end
  end

  always_comb begin
    if (ZERO_BYPASS && rar[rf_pkg::REG_W-1:0] == '0) begin
      o = '0;                 // hardwired zero register
    end else begin
      o = mem[rar];           // async read behind the address flop
    end
  end

  // an unknown write address would corrupt an arbitrary word
  a_wa_known : assert property (@(posedge clk)
    (|wr) |-> !$isunknown(wa));

endmodule

`default_nettype wire

// File: hdl/regfile_top.sv
`timescale 1ns/1ps
`default_nettype none

module regfile_top #(
  parameter bit ZERO_BYPASS = 1'b0
) (
  input  logic                      clk,
  input  logic                      rst_n,
  // alu writeback client
  input  logic                      alu_req,
  output logic                      alu_ack,
  input  logic [rf_pkg::TID_W-1:0]  alu_tid,
  input  logic [rf_pkg::REG_W-1:0]  alu_reg,
  input  logic [rf_pkg::NLANES-1:0] alu_be,
  input  rf_pkg::value_t            alu_data,
  // load writeback client
  input  logic                      ld_req,
  output logic                      ld_ack,
  input  logic [rf_pkg::TID_W-1:0]  ld_tid,
  input  logic [rf_pkg::REG_W-1:0]  ld_reg,
  input  logic [rf_pkg::NLANES-1:0] ld_be,
  input  rf_pkg::value_t            ld_data,
  // operand read client
  input  logic                      rd_req,
  output logic                      rd_ack,
  input  logic [rf_pkg::TID_W-1:0]  rd_tid,
  input  logic [rf_pkg::REG_W-1:0]  rd_reg,
  output rf_pkg::value_t            rd_data
);

  logic                      alu_pend, ld_pend, rd_pend;
  logic                      alu_done, ld_done, rd_done;
  rf_pkg::wr_req_t           alu_pl, ld_pl;  // latched write payloads
  rf_pkg::rd_req_t           rd_pl;
  logic                      rf_ce;          // driven by the read sequencer
  logic [rf_pkg::NLANES-1:0] rf_wr;
  logic [rf_pkg::ADDR_W-1:0] rf_wa, rf_ra;
  rf_pkg::value_t            rf_wdata, rf_o;

  // ============================================================
  // client slots, concat order follows the struct fields
  // ============================================================
  req_slot #(.payload_t(rf_pkg::wr_req_t)) u_alu_slot (
    .clk(clk), .rst_n(rst_n), .req(alu_req), .ack(alu_ack),
    .req_data({alu_tid, alu_reg, alu_be, alu_data}),
    .pending(alu_pend), .payload(alu_pl), .done(alu_done)
  );

  req_slot #(.payload_t(rf_pkg::wr_req_t)) u_ld_slot (
    .clk(clk), .rst_n(rst_n), .req(ld_req), .ack(ld_ack),
    .req_data({ld_tid, ld_reg, ld_be, ld_data}),
    .pending(ld_pend), .payload(ld_pl), .done(ld_done)
  );

  req_slot #(.payload_t(rf_pkg::rd_req_t)) u_rd_slot (
    .clk(clk), .rst_n(rst_n), .req(rd_req), .ack(rd_ack),
    .req_data({rd_tid, rd_reg}),
    .pending(rd_pend), .payload(rd_pl), .done(rd_done)
  );

  // ============================================================
  // write arbitration, read sequencing, storage
  // ============================================================
  wr_arbiter u_wr_arbiter (
    .clk(clk), .rst_n(rst_n),
    .pend_a(alu_pend), .pend_b(ld_pend), .req_a(alu_pl), .req_b(ld_pl),
    .done_a(alu_done), .done_b(ld_done),
    .wr(rf_wr), .wa(rf_wa), .wdata(rf_wdata)
  );

  operand_fetch u_operand_fetch (
    .clk(clk), .rst_n(rst_n), .pending(rd_pend), .rq(rd_pl), .done(rd_done),
    .ce(rf_ce), .ra(rf_ra), .o(rf_o), .rd_data(rd_data)
  );

  gpr_regfile #(.ZERO_BYPASS(ZERO_BYPASS)) u_gpr_regfile (
    .clk(clk), .ce(rf_ce), .wr(rf_wr), .wa(rf_wa), .i(rf_wdata),
    .ra(rf_ra), .o(rf_o)
  );

endmodule

`default_nettype wire

// File: dv/regfile_tb.sv
`timescale 1ns/1ps
`default_nettype none

module regfile_tb;

  // ============================================================
  // run length and timing
  // ============================================================
  localparam int RESET_CYCLES = 10;
  localparam int N_FULL  = 8;  // full mask write then read
  localparam int N_MERGE = 8;  // full write, partial write and read
  localparam int N_PAIR  = 6;  // both writers at once and two reads
  localparam int N_OPS   = 2*N_FULL + 3*N_MERGE + 4*rf_pkg::NTHREADS + 4*N_PAIR;
  localparam int TIMEOUT_CYCLES = N_OPS*8 + RESET_CYCLES;
  localparam int DLY = 1;      // drive skew after the rising edge

  typedef logic [rf_pkg::TID_W-1:0]  tid_t;
  typedef logic [rf_pkg::REG_W-1:0]  rnum_t;
  typedef logic [rf_pkg::NLANES-1:0] mask_t;

  logic           clk;
  logic           rst_n;
  logic           alu_req, ld_req, rd_req;
  logic           alu_ack, ld_ack, rd_ack;
  tid_t           alu_tid, ld_tid, rd_tid;
  rnum_t          alu_reg, ld_reg, rd_reg;
  mask_t          alu_be, ld_be;
  rf_pkg::value_t alu_data, ld_data, rd_data;
  rf_pkg::value_t exp_rd;                  // expected result of the read in flight
  rf_pkg::value_t shadow [rf_pkg::NTHREADS*rf_pkg::NREGS];  // reference copy
  logic [15:0]    lfsr = 16'd7663;
  int             cycles = 0;

  regfile_top #(.ZERO_BYPASS(1'b1)) dut (
    .clk, .rst_n,
    .alu_req, .alu_ack, .alu_tid, .alu_reg, .alu_be, .alu_data,
    .ld_req, .ld_ack, .ld_tid, .ld_reg, .ld_be, .ld_data,
    .rd_req, .rd_ack, .rd_tid, .rd_reg, .rd_data
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 100 MHz
  end

  // ============================================================
  // reference model and random source
  // ============================================================
  function automatic logic next_bit();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];  // x^16+x^14+x^13+x^11
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], next_bit()};
    end
    return v;
  endfunction

  // enabled bytes come from the new word and the others keep the old bytes
  function automatic rf_pkg::value_t merge_lanes(input rf_pkg::value_t old_v,
                                                 input rf_pkg::value_t new_v, input mask_t be);
    rf_pkg::value_t m;
    m = old_v;
    for (int l = 0; l < rf_pkg::NLANES; l++) begin
      if (be[l]) begin
        m[8*l +: 8] = new_v[8*l +: 8];
      end
    end
    return m;
  endfunction

  function automatic rf_pkg::value_t expected_value(input tid_t tid, input rnum_t rnum);
    rf_pkg::value_t v;
    v = shadow[{tid, rnum}];
    if (rnum == '0) begin
      v = '0;  // r0 hardwired with the bypass on
    end
    return v;
  endfunction

  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_failed(input string what);
    $display("Error at %0t ns: %s", $time, what);
    abort_run();
  endtask

  // ============================================================
  // four-phase client handshakes
  // ============================================================
  task automatic alu_write(input tid_t tid, input rnum_t rnum, input mask_t be,
                           input rf_pkg::value_t data);
    alu_tid  = tid;
    alu_reg  = rnum;
    alu_be   = be;
    alu_data = data;
    alu_req  = 1'b1;
    while (!alu_ack) begin
      @(posedge clk);
      #DLY;
    end
    shadow[{tid, rnum}] = merge_lanes(shadow[{tid, rnum}], data, be);  // ack is up
    alu_req = 1'b0;
    while (alu_ack) begin
      @(posedge clk);
      #DLY;
    end
  endtask

  task automatic load_write(input tid_t tid, input rnum_t rnum, input mask_t be,
                            input rf_pkg::value_t data);
    ld_tid  = tid;
    ld_reg  = rnum;
    ld_be   = be;
    ld_data = data;
    ld_req  = 1'b1;
    while (!ld_ack) begin
      @(posedge clk);
      #DLY;
    end
    shadow[{tid, rnum}] = merge_lanes(shadow[{tid, rnum}], data, be);
    ld_req = 1'b0;
    while (ld_ack) begin
      @(posedge clk);
      #DLY;
    end
  endtask

  // result is compared by a_rd_data when ack rises
  task automatic read_reg(input tid_t tid, input rnum_t rnum);
    exp_rd = expected_value(tid, rnum);
    rd_tid = tid;
    rd_reg = rnum;
    rd_req = 1'b1;
    while (!rd_ack) begin
      @(posedge clk);
      #DLY;
    end
    rd_req = 1'b0;
    while (rd_ack) begin
      @(posedge clk);
      #DLY;
    end
  endtask

  // ============================================================
  // stimulus
  // ============================================================
  initial begin
    tid_t           t, t2;
    rnum_t          r, r2;
    mask_t          be, be2;
    rf_pkg::value_t d, d2;
    {alu_req, ld_req, rd_req} = '0;
    {alu_tid, alu_reg, alu_be, alu_data} = '0;
    {ld_tid, ld_reg, ld_be, ld_data} = '0;
    {rd_tid, rd_reg} = '0;
    exp_rd = '0;
    for (int k = 0; k < rf_pkg::NTHREADS*rf_pkg::NREGS; k++) begin
      shadow[k] = '0;  // memory starts cleared
    end
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DLY rst_n = 1'b1;

    for (int k = 0; k < N_FULL; k++) begin  // full writes from alternating writers
      t = tid_t'(rand_bits(rf_pkg::TID_W));
      r = rnum_t'(rand_bits(rf_pkg::REG_W));
      if (k % 2 == 0) begin
        alu_write(t, r, '1, rand_bits(32));
      end else begin
        load_write(t, r, '1, rand_bits(32));
      end
      read_reg(t, r);
    end
    for (int k = 0; k < N_MERGE; k++) begin  // byte lane merge
      t  = tid_t'(rand_bits(rf_pkg::TID_W));
      r  = rnum_t'(rand_bits(rf_pkg::REG_W));
      be = mask_t'(rand_bits(rf_pkg::NLANES));
      load_write(t, r, '1, rand_bits(32));  // random old word under the merge
      alu_write(t, r, be, rand_bits(32));
      read_reg(t, r);
    end
    r = rnum_t'(rand_bits(rf_pkg::REG_W));
    r[0] = 1'b1;                            // keep clear of r0
    for (int k = 0; k < rf_pkg::NTHREADS; k++) begin
      load_write(tid_t'(k), r, '1, rand_bits(32));  // same register in every thread
    end
    for (int k = 0; k < rf_pkg::NTHREADS; k++) begin
      read_reg(tid_t'(k), r);
    end
    for (int k = 0; k < rf_pkg::NTHREADS; k++) begin  // r0 ignores writes
      alu_write(tid_t'(k), '0, '1, rand_bits(32));
      read_reg(tid_t'(k), '0);
    end
    for (int k = 0; k < N_PAIR; k++) begin  // contention on the write port
      t   = tid_t'(rand_bits(rf_pkg::TID_W));
      r   = rnum_t'(rand_bits(rf_pkg::REG_W));
      be  = mask_t'(rand_bits(rf_pkg::NLANES));
      d   = rand_bits(32);
      t2  = tid_t'(rand_bits(rf_pkg::TID_W));
      r2  = rnum_t'(rand_bits(rf_pkg::REG_W));
      be2 = mask_t'(rand_bits(rf_pkg::NLANES));
      d2  = rand_bits(32);
      fork
        alu_write(t, r, be, d);
        load_write(t2, r2, be2, d2);
      join
      read_reg(t, r);
      read_reg(t2, r2);
    end

    $display("NO ERRORS");
    $finish;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  // ============================================================
  // checks
  // ============================================================
  a_alu_rise : assert property (@(posedge clk) disable iff (!rst_n)
    $rose(alu_ack) |-> $past(alu_req)) else check_failed("alu ack rose with req low");
  a_ld_rise : assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ld_ack) |-> $past(ld_req)) else check_failed("load ack rose with req low");
  a_rd_rise : assert property (@(posedge clk) disable iff (!rst_n)
    $rose(rd_ack) |-> $past(rd_req)) else check_failed("read ack rose with req low");

  // ack drops one cycle after req is seen low
  a_alu_fall : assert property (@(posedge clk) disable iff (!rst_n)
    $fell(alu_req) |=> ($past(alu_ack) && !alu_ack)) else check_failed("alu ack fall late");
  a_ld_fall : assert property (@(posedge clk) disable iff (!rst_n)
    $fell(ld_req) |=> ($past(ld_ack) && !ld_ack)) else check_failed("load ack fall late");
  a_rd_fall : assert property (@(posedge clk) disable iff (!rst_n)
    $fell(rd_req) |=> ($past(rd_ack) && !rd_ack)) else check_failed("read ack fall late");

  // write ack 2 or 3 cycles after a new req and read ack after exactly 3
  a_alu_lat : assert property (@(posedge clk) disable iff (!rst_n)
    ($past(alu_req, 3) && !$past(alu_req, 4)) |-> (alu_ack || $past(alu_ack)))
    else check_failed("alu write ack not within 3 cycles");
  a_ld_lat : assert property (@(posedge clk) disable iff (!rst_n)
    ($past(ld_req, 3) && !$past(ld_req, 4)) |-> (ld_ack || $past(ld_ack)))
    else check_failed("load write ack not within 3 cycles");
  a_rd_lat : assert property (@(posedge clk) disable iff (!rst_n)
    ($past(rd_req, 3) && !$past(rd_req, 4)) |-> $rose(rd_ack))
    else check_failed("read ack not 3 cycles after req");
  a_rd_data : assert property (@(posedge clk) disable iff (!rst_n)
    $rose(rd_ack) |-> (rd_data == exp_rd))
    else check_failed($sformatf("read t%0d r%0d got %h, expected %h",
                                rd_tid, rd_reg, rd_data, exp_rd));

endmodule

`default_nettype wire

// File: sources.f
hdl/rf_pkg.sv
hdl/req_slot.sv
hdl/wr_arbiter.sv
hdl/operand_fetch.sv
hdl/gpr_regfile.sv
hdl/regfile_top.sv
dv/regfile_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := regfile_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
PASS_MSG  := NO ERRORS
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the simulation output holds the pass line
run: compile
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
